// ==== Bender.yml ====
package:
  name: rst_ctrl

sources:
  - files:
      - hdl/rst_pkg.sv
      - hdl/rst_req_if.sv
      - hdl/rst_watchdog.sv
      - hdl/rst_cause_decode.sv
      - hdl/rst_status_pipe.sv
      - hdl/rst_sequencer.sv
      - hdl/rst_ctrl_top.sv
  - target: test
    files:
      - verification/rst_ctrl_assertions.sv
      - verification/rst_ctrl_tb.sv

// ==== flist.f ====
hdl/rst_pkg.sv
hdl/rst_req_if.sv
hdl/rst_watchdog.sv
hdl/rst_cause_decode.sv
hdl/rst_status_pipe.sv
hdl/rst_sequencer.sv
hdl/rst_ctrl_top.sv
verification/rst_ctrl_assertions.sv
verification/rst_ctrl_tb.sv

// ==== hdl/rst_cause_decode.sv ====
// ====================================================================
// Reset request decode: pin synchronizer, edge detectors, request set
// ====================================================================
`timescale 1ns/1ns
`default_nettype none

module rst_cause_decode (
  input  logic      clk,
  input  logic      pwr_rst,
  input  logic      ext_rst_n,
  input  logic      sw_rst_req,
  input  logic      status_clear,
  input  logic      expire,
  rst_req_if.source req
);

  // External pin synchronizer and delayed copy for the edge detector
  logic ext_s1;
  logic ext_s2;
  logic ext_s3;

  // Previous levels of the strobes
  logic sw_q;
  logic clr_q;

  logic ext_fall;
  logic sw_rise;
  logic clr_rise;

  always_ff @(posedge clk or posedge pwr_rst) begin
    if (pwr_rst) begin
      // Pin idles high
      ext_s1 <= 1'b1;
      ext_s2 <= 1'b1;
      ext_s3 <= 1'b1;
      sw_q   <= 1'b0;
      clr_q  <= 1'b0;
    end else begin
      ext_s1 <= ext_rst_n;
      ext_s2 <= ext_s1;
      ext_s3 <= ext_s2;
      sw_q   <= sw_rst_req;
      clr_q  <= status_clear;
    end
  end

  assign ext_fall = ext_s3 & ~ext_s2;
  assign sw_rise  = sw_rst_req & ~sw_q;
  assign clr_rise = status_clear & ~clr_q;

  // One registered request per cycle with any event
  always_ff @(posedge clk or posedge pwr_rst) begin
    if (pwr_rst) begin
      req.valid <= 1'b0;
      req.clear <= 1'b0;
      req.wdt   <= 1'b0;
      req.sw    <= 1'b0;
      req.ext   <= 1'b0;
    end else begin
      req.valid <= ext_fall | sw_rise | clr_rise | expire;
      req.clear <= clr_rise;
      req.wdt   <= expire;
      req.sw    <= sw_rise;
      req.ext   <= ext_fall;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rst_ctrl_top.sv ====
// ====================================================================
// Reset management unit top level, decode, status pipe and sequencer
// ====================================================================
`timescale 1ns/1ns
`default_nettype none

module rst_ctrl_top import rst_pkg::*; #(
  parameter int WDT_TIMEOUT = 40,
  parameter int RST_HOLD    = 8
) (
  input  logic        clk,
  input  logic        pwr_rst,
  input  logic        ext_rst_n,
  input  logic        sw_rst_req,
  input  logic        status_clear,
  input  logic        wdt_kick,
  output logic        sys_rst,
  output logic        status_valid,
  output rst_status_t rst_status
);

  logic expire;

  rst_req_if req_bus ();

  rst_watchdog #(
    .WDT_TIMEOUT (WDT_TIMEOUT)
  ) i_watchdog (
    .clk     (clk),
    .pwr_rst (pwr_rst),
    .kick    (wdt_kick),
    .sys_rst (sys_rst),
    .expire  (expire)
  );

  rst_cause_decode i_decode (
    .clk          (clk),
    .pwr_rst      (pwr_rst),
    .ext_rst_n    (ext_rst_n),
    .sw_rst_req   (sw_rst_req),
    .status_clear (status_clear),
    .expire       (expire),
    .req          (req_bus.source)
  );

  rst_status_pipe i_status (
    .clk          (clk),
    .pwr_rst      (pwr_rst),
    .req          (req_bus.sink),
    .status_valid (status_valid),
    .rst_status   (rst_status)
  );

  rst_sequencer #(
    .RST_HOLD (RST_HOLD)
  ) i_sequencer (
    .clk     (clk),
    .pwr_rst (pwr_rst),
    .req     (req_bus.monitor),
    .sys_rst (sys_rst)
  );

endmodule

`default_nettype wire

// ==== hdl/rst_pkg.sv ====
// ====================================================================
// Shared types and constants of the reset management unit
// ====================================================================
`default_nettype none

package rst_pkg;

  // Reset cause register value
  typedef logic [7:0] rst_status_t;

  // Cause bit positions within rst_status_t
  localparam int RST_CAUSE_POR = 0;
  localparam int RST_CAUSE_WDT = 1;
  localparam int RST_CAUSE_SW  = 2;
  localparam int RST_CAUSE_EXT = 3;

  // Status after power-on, only the power-on bit set
  localparam rst_status_t RST_STATUS_POR = 8'h01;

  // Counter word of the watchdog and the sequencer
  typedef logic [15:0] rst_cnt_t;

  // Sequencer states
  typedef enum logic {
    SEQ_HOLD,
    SEQ_RUN
  } rst_seq_state_t;

endpackage

`default_nettype wire

// ==== hdl/rst_req_if.sv ====
// ====================================================================
// Decoded reset request set, decode to status pipe and sequencer
// ====================================================================
`timescale 1ns/1ns
`default_nettype none

interface rst_req_if;

  logic valid;
  logic clear;
  logic wdt;
  logic sw;
  logic ext;

  modport source (output valid, output clear, output wdt, output sw, output ext);

  modport sink (input valid, input clear, input wdt, input sw, input ext);

  // Sequencer only reacts to causes
  modport monitor (input valid, input wdt, input sw, input ext);

endinterface

`default_nettype wire

// ==== hdl/rst_sequencer.sv ====
// ====================================================================
// System reset sequencer, holds sys_rst for RST_HOLD cycles
// ====================================================================
`timescale 1ns/1ns
`default_nettype none

module rst_sequencer import rst_pkg::*; #(
  parameter int RST_HOLD = 8
) (
  input  logic       clk,
  input  logic       pwr_rst,
  rst_req_if.monitor req,
  output logic       sys_rst
);

  localparam rst_cnt_t HOLD_LOAD = rst_cnt_t'(RST_HOLD);

  rst_seq_state_t state;
  rst_cnt_t       hold_cnt;
  logic           cause;

  // Clear alone is not a cause
  assign cause = req.valid & (req.wdt | req.sw | req.ext);

  always_ff @(posedge clk or posedge pwr_rst) begin
    if (pwr_rst) begin
      state    <= SEQ_HOLD;
      hold_cnt <= HOLD_LOAD;
    end else if (cause) begin
      // Restart the hold from either state
      state    <= SEQ_HOLD;
      hold_cnt <= HOLD_LOAD;
    end else begin
      case (state)
        SEQ_HOLD: begin
          if (hold_cnt <= rst_cnt_t'(1)) begin
            state <= SEQ_RUN;
          end else begin
            hold_cnt <= hold_cnt - rst_cnt_t'(1);
          end
        end
        SEQ_RUN: begin
          state <= SEQ_RUN;
        end
        default: begin
          state <= SEQ_HOLD;
        end
      endcase
    end
  end

  assign sys_rst = (state == SEQ_HOLD);

endmodule

`default_nettype wire

// ==== hdl/rst_status_pipe.sv ====
// ====================================================================
// Reset cause status register as a three-stage pipeline
// ====================================================================
`timescale 1ns/1ns
`default_nettype none

module rst_status_pipe import rst_pkg::*; (
  input  logic        clk,
  input  logic        pwr_rst,
  rst_req_if.sink     req,
  output logic        status_valid,
  output rst_status_t rst_status
);

  rst_status_t cause_set;

  // Stage 1 keeps the running status
  rst_status_t s1_status;
  logic        s1_valid;

  // Stage 2 only carries the value along
  rst_status_t s2_status;
  logic        s2_valid;

  // Cause bits requested in this cycle
  always_comb begin
    cause_set                = '0;
    cause_set[RST_CAUSE_WDT] = req.wdt;
    cause_set[RST_CAUSE_SW]  = req.sw;
    cause_set[RST_CAUSE_EXT] = req.ext;
  end

  always_ff @(posedge clk or posedge pwr_rst) begin
    if (pwr_rst) begin
      s1_status <= RST_STATUS_POR;
      s1_valid  <= 1'b0;
    end else begin
      s1_valid <= req.valid;
      if (req.valid) begin
        // Clear wins over any cause in the same request
        if (req.clear) begin
          s1_status <= '0;
        end else begin
          s1_status <= s1_status | cause_set;
        end
      end
    end
  end

  always_ff @(posedge clk or posedge pwr_rst) begin
    if (pwr_rst) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2_status <= s1_status;
    end
  end

  // Output register moves only with its valid
  always_ff @(posedge clk or posedge pwr_rst) begin
    if (pwr_rst) begin
      status_valid <= 1'b0;
      rst_status   <= RST_STATUS_POR;
    end else begin
      status_valid <= s2_valid;
      if (s2_valid) begin
        rst_status <= s2_status;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rst_watchdog.sv ====
// ====================================================================
// Watchdog counter, expires after WDT_TIMEOUT cycles without a kick
// ====================================================================
`timescale 1ns/1ns
`default_nettype none

module rst_watchdog import rst_pkg::*; #(
  parameter int WDT_TIMEOUT = 40
) (
  input  logic clk,
  input  logic pwr_rst,
  input  logic kick,
  input  logic sys_rst,
  output logic expire
);

  // Count value in the cycle that fires
  localparam rst_cnt_t CNT_LAST = rst_cnt_t'(WDT_TIMEOUT - 1);

  rst_cnt_t cnt;

  always_ff @(posedge clk or posedge pwr_rst) begin
    if (pwr_rst) begin
      cnt    <= '0;
      expire <= 1'b0;
    end else begin
      expire <= 1'b0;
      if (sys_rst) begin
        // Held at zero while the system is in reset
        cnt <= '0;
      end else if (kick) begin
        cnt <= '0;
      end else if (cnt == CNT_LAST) begin
        cnt    <= '0;
        expire <= 1'b1;
      end else begin
        cnt <= cnt + rst_cnt_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/rst_ctrl_assertions.sv ====
// ====================================================================
// Concurrent assertions on the reset unit top level, attached by bind
// ====================================================================
`timescale 1ns/1ns
`default_nettype none

module rst_ctrl_assertions #(
  parameter int RST_HOLD = 8
) (
  input logic clk,
  input logic pwr_rst,
  input logic req_valid,
  input logic status_valid,
  input logic sys_rst
);

  // Status pipe latency is exactly three cycles
  req_to_status: assert property (@(posedge clk) disable iff (pwr_rst)
    req_valid |-> ##3 status_valid)
    else $error("status_valid missing three cycles after a request");

  status_from_req: assert property (@(posedge clk) disable iff (pwr_rst)
    status_valid |-> $past(req_valid, 3))
    else $error("status_valid without a request three cycles earlier");

  sys_rst_hold: assert property (@(posedge clk) disable iff (pwr_rst)
    $rose(sys_rst) |-> sys_rst [*RST_HOLD])
    else $error("sys_rst dropped before the hold time");

  no_status_in_reset: assert property (@(posedge clk)
    pwr_rst |-> !status_valid)
    else $error("status_valid high during power-on reset");

endmodule

bind rst_ctrl_top rst_ctrl_assertions #(
  .RST_HOLD (RST_HOLD)
) i_assertions (
  .clk          (clk),
  .pwr_rst      (pwr_rst),
  .req_valid    (req_bus.valid),
  .status_valid (status_valid),
  .sys_rst      (sys_rst)
);

`default_nettype wire

// ==== verification/rst_ctrl_tb.sv ====
// ====================================================================
// Testbench of the reset unit: file-driven stimulus, cycle model, checks
// ====================================================================
`timescale 1ns/1ns
`default_nettype none

module rst_ctrl_tb import rst_pkg::*;;

  localparam int WDT_TIMEOUT = 40;
  localparam int RST_HOLD    = 8;
  localparam int CLR_BIT     = 7;
  localparam logic [7:0] CAUSE_MASK = 8'h0E;

  logic        clk = 1'b0;
  logic        pwr_rst;
  logic        ext_rst_n;
  logic        sw_rst_req;
  logic        status_clear;
  logic        wdt_kick;
  logic        sys_rst;
  logic        status_valid;
  rst_status_t rst_status;

  // Test sequence from the data file
  string       name_q[$];
  string       cmd_q[$];
  int          arg_q[$];
  string       cur_test = "reset";
  int          limit_cycles = 0;
  int          errors = 0;
  int          checks = 0;
  logic [31:0] seed = 32'h08417c34;

  // Reference model state, cycles counted from the release of pwr_rst
  int          cyc = 0;
  int          wdt_idle = 0;
  int          rst_begin = 0;
  int          rst_end = RST_HOLD;
  logic [7:0]  m_status = 8'h01;
  logic [7:0]  ring[8] = '{default: 8'h00};
  logic [7:0]  ev;
  logic        sw_prev = 1'b0;
  logic        clr_prev = 1'b0;
  logic        ext_prev = 1'b1;
  logic [7:0]  exp_q[$];

  rst_ctrl_top #(
    .WDT_TIMEOUT (WDT_TIMEOUT),
    .RST_HOLD    (RST_HOLD)
  ) i_dut (
    .clk          (clk),
    .pwr_rst      (pwr_rst),
    .ext_rst_n    (ext_rst_n),
    .sw_rst_req   (sw_rst_req),
    .status_clear (status_clear),
    .wdt_kick     (wdt_kick),
    .sys_rst      (sys_rst),
    .status_valid (status_valid),
    .rst_status   (rst_status)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // True when sys_rst is expected high at posedge p
  function automatic bit rst_high(input int p);
    return (p >= rst_begin) && (p <= rst_end);
  endfunction

  task automatic check_value(input string what, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error: %s expected %02h actual %02h", what, exp, act);
    end
  endtask

  // Kind 0 ext pin low, 1 software request, 2 clear, 3 kick
  task automatic drive_pulse(input int kind);
    case (kind)
      0: ext_rst_n = 1'b0;
      1: sw_rst_req = 1'b1;
      2: status_clear = 1'b1;
      default: wdt_kick = 1'b1;
    endcase
    @(negedge clk);
    ext_rst_n    = 1'b1;
    sw_rst_req   = 1'b0;
    status_clear = 1'b0;
    wdt_kick     = 1'b0;
    @(negedge clk);
  endtask

  task automatic run_burst(input int count);
    for (int k = 0; k < count; k++) begin
      seed = lcg_next(seed);
      drive_pulse(int'(seed[31:30]));
    end
  endtask

  // Cycle model of decode latency, watchdog, sequencer and status rules
  always @(posedge clk) begin
    if (!pwr_rst) begin
      cyc = cyc + 1;
      if (rst_high(cyc) || wdt_kick) begin
        wdt_idle = 0;
      end else if (wdt_idle == WDT_TIMEOUT - 1) begin
        wdt_idle = 0;
        ring[(cyc + 1) % 8][RST_CAUSE_WDT] = 1'b1;
      end else begin
        wdt_idle = wdt_idle + 1;
      end
      if (sw_rst_req && !sw_prev) ring[cyc % 8][RST_CAUSE_SW] = 1'b1;
      if (status_clear && !clr_prev) ring[cyc % 8][CLR_BIT] = 1'b1;
      // Two synchronizer flops delay the pin by two more cycles
      if (!ext_rst_n && ext_prev) ring[(cyc + 2) % 8][RST_CAUSE_EXT] = 1'b1;
      sw_prev  = sw_rst_req;
      clr_prev = status_clear;
      ext_prev = ext_rst_n;
      ev = ring[cyc % 8];
      ring[cyc % 8] = 8'h00;
      if (ev != 8'h00) begin
        // Clear wins over causes of the same request
        m_status = ev[CLR_BIT] ? 8'h00 : (m_status | (ev & CAUSE_MASK));
        exp_q.push_back(m_status);
        if ((ev & CAUSE_MASK) != 8'h00) begin
          if (cyc + 1 > rst_end) rst_begin = cyc + 2;
          rst_end = cyc + RST_HOLD + 1;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (cyc > 0) begin
      check_value({cur_test, " sys_rst"}, {7'd0, rst_high(cyc + 1)}, {7'd0, sys_rst});
      if (status_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Test %s: status_valid pulsed with no request pending", cur_test);
        end else begin
          check_value({cur_test, " status"}, exp_q.pop_front(), rst_status);
        end
      end
    end
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: the test sequence did not end within %0d cycles", limit_cycles);
    $display("Verification failed");
    $finish;
  end

  initial begin
    int    fd;
    int    n;
    int    arg;
    int    limit;
    string line;
    string name;
    string cmd;
    string arg_str;
    pwr_rst      = 1'b1;
    ext_rst_n    = 1'b1;
    sw_rst_req   = 1'b0;
    status_clear = 1'b0;
    wdt_kick     = 1'b0;
    limit        = 0;
    fd = $fopen("verification/rst_ctrl_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open the test file verification/rst_ctrl_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %s %s", name, cmd, arg_str);
          if (n == 3) begin
            if (cmd == "expect") n = $sscanf(arg_str, "%h", arg);
            else n = $sscanf(arg_str, "%d", arg);
            name_q.push_back(name);
            cmd_q.push_back(cmd);
            arg_q.push_back(arg);
            limit = limit + 200;
            if (cmd == "idle") limit = limit + arg;
          end
        end
      end
      $fclose(fd);
    end
    limit_cycles = limit;
    repeat (4) @(negedge clk);
    pwr_rst = 1'b0;
    for (int i = 0; i < cmd_q.size(); i++) begin
      cur_test = name_q[i];
      arg = arg_q[i];
      case (cmd_q[i])
        "ext":    drive_pulse(0);
        "sw":     drive_pulse(1);
        "clear":  drive_pulse(2);
        "kick":   drive_pulse(3);
        "idle":   repeat (arg) @(negedge clk);
        "burst":  run_burst(arg);
        "expect": check_value({cur_test, " rst_status"}, arg[7:0], rst_status);
        default: begin
          errors++;
          $display("Test %s: unknown command %s", cur_test, cmd_q[i]);
        end
      endcase
    end
    // Let the status pipeline drain
    repeat (4) @(negedge clk);
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d requests never produced a status_valid pulse", exp_q.size());
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/rst_ctrl_tests.txt ====
# Columns: test name, command, argument
# ext, sw, clear and kick pulse one input; idle and burst take a cycle count in decimal
# expect compares rst_status with a hex value; pulse commands ignore the argument
por      expect  01
por      idle    12
sw_ext   sw      0
sw_ext   idle    12
sw_ext   expect  05
sw_ext   ext     0
sw_ext   idle    12
sw_ext   expect  0d
clear    clear   0
clear    idle    6
clear    expect  00
kick     kick    0
kick     idle    30
kick     kick    0
kick     idle    30
kick     kick    0
kick     idle    30
kick     expect  00
wdt      idle    20
wdt      expect  02
burst    kick    0
burst    burst   24
burst    idle    20
burst    kick    0
burst    clear   0
burst    idle    6
burst    expect  00
